// ==== fetch_skid_buffer.sv ====
`timescale 1ns/1ps

module fetch_skid_buffer
  import icache_pkg::*;
(
  input  logic       core_clock_i,
  input  logic       rst_i,
  input  logic       flush_i,
  input  logic       stall_i,
  input  logic       in_vld_i,
  input  fetch_req_t in_req_i,
  output logic       busy_o,
  output logic       out_vld_o,
  output fetch_req_t out_req_o
);

  logic       main_vld_q;
  fetch_req_t main_q;
  logic       skid_vld_q;
  fetch_req_t skid_q;
  logic       main_free;
  logic       take_in;

  // The main register may load when the controller consumes it or when it holds nothing
  assign main_free = !stall_i || !main_vld_q;
  // Fetch is refused while the skid slot is occupied and has to hold its request
  assign take_in   = in_vld_i && !skid_vld_q;

  assign busy_o    = skid_vld_q;
  assign out_vld_o = main_vld_q;
  assign out_req_o = main_q;

  always_ff @(posedge core_clock_i) begin
    if (rst_i || flush_i) begin
      main_vld_q <= 1'b0;
      skid_vld_q <= 1'b0;
    end else if (main_free) begin
      // A parked request always drains ahead of anything new from fetch
      if (skid_vld_q) begin
        main_vld_q <= 1'b1;
        skid_vld_q <= 1'b0;
      end else begin
        main_vld_q <= take_in;
      end
    end else if (take_in) begin
      skid_vld_q <= 1'b1;
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (main_free) begin
      main_q <= skid_vld_q ? skid_q : in_req_i;
    end
    // The skid slot only captures while the head is stuck and the slot is empty
    if (!main_free && !skid_vld_q) begin
      skid_q <= in_req_i;
    end
  end

  // A parked request survives untouched for as long as the head stays stalled
  skid_held: assert property (@(posedge core_clock_i) disable iff (rst_i || flush_i)
    skid_vld_q && !main_free |=> skid_vld_q && $stable(skid_q));

endmodule

// ==== icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl
  import icache_pkg::*;
#(
  parameter  int CACHE_BYTES = 4096,
  localparam int IDX_W       = $clog2(CACHE_BYTES / 256),
  localparam int PAIR_W      = $clog2(LINE_BEATS) - 1,
  localparam int RAM_AW      = 1 + IDX_W + PAIR_W
) (
  input  logic              core_clock_i,
  input  logic              rst_i,
  input  logic              core_flush_i,
  input  logic              cache_flush_i,
  output logic              flush_resp_o,
  input  logic              work_vld_i,
  input  fetch_req_t        work_req_i,
  output logic              stall_o,
  output logic [24:0]       pmp_addr_o,
  input  logic              pmp_kill_i,
  input  logic [1:0]        hit_way_i,
  input  logic              victim_way_i,
  output logic              fill_en_o,
  output logic              fill_way_o,
  output logic              flush_en_o,
  output logic [IDX_W-1:0]  flush_idx_o,
  input  logic              flush_done_i,
  output logic              ram_rd_en_o,
  output logic [RAM_AW-1:0] ram_rd_addr_o,
  output logic              ram_wr_en_o,
  output logic [RAM_AW-1:0] ram_wr_addr_o,
  output logic [63:0]       ram_wr_data_o,
  output logic              dec_vld_o,
  output dec_out_t          dec_meta_o,
  input  logic              dec_busy_i,
  output tl_a_t             a_o,
  output logic              a_valid_o,
  input  logic              a_ready_i,
  input  tl_d_t             d_i,
  input  logic              d_valid_i,
  output logic              d_ready_o
);

  localparam int BEAT_W = $clog2(LINE_BEATS);

  cache_state_e      state_q;
  logic              block_q;
  logic              refill_drop_q;
  logic              fill_way_q;
  logic [BEAT_W-1:0] beat_q;
  logic [31:0]       even_q;
  logic [IDX_W-1:0]  flush_cnt_q;
  logic [24:0]       miss_line_q;
  logic [29:0]       ppc;
  logic              idle;
  logic              hit;
  logic              fault;
  logic              lookup_ok;
  logic              take;
  logic              miss_start;
  logic              flush_start;
  logic              beat;
  logic              last_beat;
  logic              drop;

  assign ppc   = work_req_i.ppc;
  assign idle  = state_q == IDLE;
  assign hit   = |hit_way_i;
  // Bit 29 marks the uncacheable or invalid region, the checker adds its own kill
  assign fault = ppc[29] || pmp_kill_i;

  // A cache flush only starts from IDLE, and a front-end flush takes priority
  assign flush_start = idle && !core_flush_i && cache_flush_i;
  // The head is looked up only when no flush, block or busy decode claims the cycle
  assign lookup_ok   = idle && !core_flush_i && !cache_flush_i && !block_q &&
                       !dec_busy_i && work_vld_i;
  // Faults are answered straight away without touching the bus
  assign take        = lookup_ok && (hit || fault);
  assign miss_start  = lookup_ok && !hit && !fault;

  // The head stays put during a refill so it can be looked up again afterwards
  assign stall_o = dec_busy_i || !idle || miss_start || flush_start || block_q;

  assign pmp_addr_o   = ppc[29:5];
  assign flush_resp_o = idle;
  assign d_ready_o    = 1'b1;

  // Every valid D-channel cycle during the refill is one beat
  assign beat      = (state_q == MISS_RESP) && d_valid_i;
  assign last_beat = beat && (beat_q == BEAT_W'(LINE_BEATS - 1));
  // A front-end flush mid-refill drains the bus but installs nothing,
  // since the head it was fetching for may already be gone
  assign drop      = refill_drop_q || core_flush_i;

  // The even beat waits in a register and is written together with the odd one
  assign ram_wr_en_o   = beat && beat_q[0] && !drop;
  assign ram_wr_addr_o = {fill_way_q, ppc[BEAT_W +: IDX_W], beat_q[BEAT_W-1:1]};
  assign ram_wr_data_o = {d_i.data, even_q};
  assign fill_en_o     = last_beat && !drop;
  assign fill_way_o    = fill_way_q;

  // A fault reads whichever way, the data is ignored once the exception is flagged
  assign ram_rd_en_o   = take;
  assign ram_rd_addr_o = {hit_way_i[1], ppc[BEAT_W +: IDX_W], ppc[BEAT_W-1:1]};

  assign flush_en_o  = state_q == CFLUSH;
  assign flush_idx_o = flush_cnt_q;

  always_ff @(posedge core_clock_i) begin
    if (rst_i) begin
      state_q       <= IDLE;
      block_q       <= 1'b0;
      refill_drop_q <= 1'b0;
      beat_q        <= '0;
      flush_cnt_q   <= '0;
      a_valid_o     <= 1'b0;
      dec_vld_o     <= 1'b0;
    end else begin
      // The output holds while decode is busy and is thrown away on a front-end flush
      if (core_flush_i) begin
        dec_vld_o <= 1'b0;
      end else if (!dec_busy_i) begin
        dec_vld_o <= take;
      end
      case (state_q)
        IDLE: begin
          if (core_flush_i) begin
            block_q <= 1'b0;
          end else if (flush_start) begin
            state_q <= CFLUSH;
          end else if (miss_start) begin
            state_q       <= MISS_REQ;
            refill_drop_q <= 1'b0;
          end
        end
        MISS_REQ: begin
          state_q   <= MISS_RESP;
          a_valid_o <= 1'b1;
          if (core_flush_i) begin
            refill_drop_q <= 1'b1;
          end
        end
        MISS_RESP: begin
          if (a_ready_i) begin
            a_valid_o <= 1'b0;
          end
          if (core_flush_i) begin
            refill_drop_q <= 1'b1;
          end
          // The counter wraps back to zero on the 32nd beat
          if (beat) begin
            beat_q <= beat_q + 1'b1;
          end
          if (last_beat) begin
            state_q <= IDLE;
          end
        end
        CFLUSH: begin
          flush_cnt_q <= flush_cnt_q + 1'b1;
          // Delivery stays blocked until the core flushes the front end
          if (flush_done_i) begin
            state_q <= IDLE;
            block_q <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge core_clock_i) begin
    // Victim and line address are frozen when the miss is seen
    if (miss_start) begin
      miss_line_q <= ppc[29:5];
      fill_way_q  <= victim_way_i;
    end
    if (state_q == MISS_REQ) begin
      a_o.opcode  <= TL_GET;
      a_o.param   <= 3'd0;
      a_o.size    <= 4'(TL_SIZE_LINE);
      a_o.address <= {miss_line_q, 7'h00};
      a_o.mask    <= 4'hf;
      a_o.data    <= 32'h0;
      a_o.corrupt <= 1'b0;
    end
    if (beat && !beat_q[0]) begin
      even_q <= d_i.data;
    end
    // The instruction field is filled in from the data RAM at the top level
    if (take) begin
      dec_meta_o.vpc       <= ppc;
      dec_meta_o.instr     <= '0;
      dec_meta_o.excp_code <= EXCP_INSTR_ACCESS_FAULT;
      dec_meta_o.excp_vld  <= fault;
      dec_meta_o.btb       <= work_req_i.btb;
    end
  end

  // A Get stays offered until the bus has taken it
  a_valid_until_ready: assert property (@(posedge core_clock_i) disable iff (rst_i)
    a_valid_o && !a_ready_i |=> a_valid_o);

  // Data beats only come back for a refill that is in flight
  d_beat_in_refill: assert property (@(posedge core_clock_i) disable iff (rst_i)
    d_valid_i |-> state_q == MISS_RESP);

endmodule

// ==== icache_data_ram.sv ====
`timescale 1ns/1ps

module icache_data_ram #(
  parameter  int CACHE_BYTES = 4096,
  localparam int AW          = $clog2(CACHE_BYTES / 8)
) (
  input  logic          core_clock_i,
  input  logic          rd_en_i,
  input  logic [AW-1:0] rd_addr_i,
  output logic [63:0]   rd_data_o,
  input  logic          wr_en_i,
  input  logic [AW-1:0] wr_addr_i,
  input  logic [63:0]   wr_data_i
);

  // One entry per instruction pair, addressed as way, set and pair within the line
  logic [63:0] mem_q [CACHE_BYTES / 8];

  // Refill writes one pair on every odd beat of the D channel
  always_ff @(posedge core_clock_i) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // The read register only moves on a new lookup
  // so decode sees stable data while it is busy
  always_ff @(posedge core_clock_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];
    end
  end

endmodule

// ==== icache_pkg.sv ====
package icache_pkg;

  // A line is 128 bytes, delivered as 32 beats of one 32-bit word each
  localparam int LINE_BEATS = 32;

  // TileLink encodes the transfer size as log2 of the byte count
  localparam int TL_SIZE_LINE = 7;

  // Only the access fault is ever raised by the instruction cache
  typedef enum logic [3:0] {
    EXCP_INSTR_ACCESS_FAULT = 4'd1
  } excp_code_e;

  // The cache only ever reads, so Get is the single A-channel opcode
  typedef enum logic [2:0] {
    TL_GET = 3'd4
  } tl_a_opcode_e;

  typedef enum logic [1:0] {
    IDLE,
    MISS_REQ,
    MISS_RESP,
    CFLUSH
  } cache_state_e;

  // Branch predictor sideband, passed through to decode untouched
  typedef struct packed {
    logic        index;
    logic [1:0]  btype;
    logic [1:0]  bm_pred;
    logic [29:0] target;
    logic        vld;
    logic        way;
  } btb_info_t;

  typedef struct packed {
    logic [29:0] ppc;
    btb_info_t   btb;
  } fetch_req_t;

  typedef struct packed {
    logic [29:0] vpc;
    logic [63:0] instr;
    excp_code_e  excp_code;
    logic        excp_vld;
    btb_info_t   btb;
  } dec_out_t;

  typedef struct packed {
    tl_a_opcode_e opcode;
    logic [2:0]   param;
    logic [3:0]   size;
    logic [31:0]  address;
    logic [3:0]   mask;
    logic [31:0]  data;
    logic         corrupt;
  } tl_a_t;

  typedef struct packed {
    logic [2:0]  opcode;
    logic [1:0]  param;
    logic [3:0]  size;
    logic        denied;
    logic [31:0] data;
    logic        corrupt;
  } tl_d_t;

endpackage

// ==== icache_tag_array.sv ====
`timescale 1ns/1ps

module icache_tag_array
  import icache_pkg::*;
#(
  parameter  int CACHE_BYTES = 4096,
  localparam int SETS        = CACHE_BYTES / 256,
  localparam int IDX_W       = $clog2(SETS)
) (
  input  logic             core_clock_i,
  input  logic             rst_i,
  input  logic [29:0]      lookup_addr_i,
  output logic [1:0]       hit_way_o,
  output logic             victim_way_o,
  input  logic             fill_en_i,
  input  logic             fill_way_i,
  input  logic             flush_en_i,
  input  logic [IDX_W-1:0] flush_idx_i,
  output logic             flush_done_o
);

  // The lookup address is a word address, so the line offset is log2 of the beat count
  localparam int OFF_W = $clog2(LINE_BEATS);
  localparam int TAG_W = 30 - OFF_W - IDX_W;

  logic [TAG_W-1:0] tag_q [2][SETS];
  logic [SETS-1:0]  valid_q [2];
  logic             toggle_q;
  logic [IDX_W-1:0] set_idx;
  logic [TAG_W-1:0] tag_in;
  logic             both_valid;

  assign set_idx = lookup_addr_i[OFF_W +: IDX_W];
  assign tag_in  = lookup_addr_i[29 -: TAG_W];

  // Both ways are compared in parallel against the head request
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      hit_way_o[w] = valid_q[w][set_idx] && (tag_q[w][set_idx] == tag_in);
    end
  end

  // An empty way is filled first, way 1 ahead of way 0
  // Once the set is full the toggle picks a pseudo-random victim
  assign both_valid   = valid_q[0][set_idx] && valid_q[1][set_idx];
  assign victim_way_o = both_valid ? toggle_q : !valid_q[1][set_idx];

  // The sweep is over once the last set index has been cleared
  assign flush_done_o = flush_en_i && (flush_idx_i == IDX_W'(SETS - 1));

  always_ff @(posedge core_clock_i) begin
    if (rst_i) begin
      valid_q[0] <= '0;
      valid_q[1] <= '0;
      toggle_q   <= 1'b0;
    end else begin
      // Free-running, so the victim depends on when the miss happens
      toggle_q <= !toggle_q;
      if (fill_en_i) begin
        valid_q[fill_way_i][set_idx] <= 1'b1;
      end
      // One set per cycle, both ways at once
      if (flush_en_i) begin
        valid_q[0][flush_idx_i] <= 1'b0;
        valid_q[1][flush_idx_i] <= 1'b0;
      end
    end
  end

  // The tag goes in together with the last refill beat
  always_ff @(posedge core_clock_i) begin
    if (fill_en_i) begin
      tag_q[fill_way_i][set_idx] <= tag_in;
    end
  end

  // Refill only installs a line that missed, so one line never sits in both ways
  one_hot_hit: assert property (@(posedge core_clock_i) disable iff (rst_i)
    !(hit_way_o[0] && hit_way_o[1]));

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
#(
  parameter int CACHE_BYTES = 4096
) (
  input  logic       core_clock_i,
  input  logic       rst_i,
  input  logic       core_flush_i,
  input  logic       fetch_vld_i,
  input  fetch_req_t fetch_req_i,
  output logic       icache_busy_o,
  output logic       dec_vld_o,
  output dec_out_t   dec_o,
  input  logic       dec_busy_i,
  input  logic       cache_flush_i,
  output logic       flush_resp_o,
  output tl_a_t      a_o,
  output logic       a_valid_o,
  input  logic       a_ready_i,
  input  tl_d_t      d_i,
  input  logic       d_valid_i,
  output logic       d_ready_o,
  output logic [24:0] pmp_addr_o,
  input  logic       pmp_kill_i
);

  localparam int IDX_W  = $clog2(CACHE_BYTES / 256);
  localparam int RAM_AW = $clog2(CACHE_BYTES / 8);

  // Two ways of 128-byte lines need at least two sets
  if (CACHE_BYTES < 512 || (CACHE_BYTES & (CACHE_BYTES - 1)) != 0) begin : g_bad_size
    $error("CACHE_BYTES must be a power of two and at least 512");
  end

  logic              work_vld;
  fetch_req_t        work_req;
  logic              stall;
  logic [1:0]        hit_way;
  logic              victim_way;
  logic              fill_en;
  logic              fill_way;
  logic              flush_en;
  logic [IDX_W-1:0]  flush_idx;
  logic              flush_done;
  logic              ram_rd_en;
  logic [RAM_AW-1:0] ram_rd_addr;
  logic [63:0]       ram_rd_data;
  logic              ram_wr_en;
  logic [RAM_AW-1:0] ram_wr_addr;
  logic [63:0]       ram_wr_data;
  dec_out_t          dec_meta;

  fetch_skid_buffer u_skid (
    .core_clock_i (core_clock_i),
    .rst_i        (rst_i),
    .flush_i      (core_flush_i),
    .stall_i      (stall),
    .in_vld_i     (fetch_vld_i),
    .in_req_i     (fetch_req_i),
    .busy_o       (icache_busy_o),
    .out_vld_o    (work_vld),
    .out_req_o    (work_req)
  );

  icache_tag_array #(.CACHE_BYTES(CACHE_BYTES)) u_tags (
    .core_clock_i  (core_clock_i),
    .rst_i         (rst_i),
    .lookup_addr_i (work_req.ppc),
    .hit_way_o     (hit_way),
    .victim_way_o  (victim_way),
    .fill_en_i     (fill_en),
    .fill_way_i    (fill_way),
    .flush_en_i    (flush_en),
    .flush_idx_i   (flush_idx),
    .flush_done_o  (flush_done)
  );

  icache_data_ram #(.CACHE_BYTES(CACHE_BYTES)) u_ram (
    .core_clock_i (core_clock_i),
    .rd_en_i      (ram_rd_en),
    .rd_addr_i    (ram_rd_addr),
    .rd_data_o    (ram_rd_data),
    .wr_en_i      (ram_wr_en),
    .wr_addr_i    (ram_wr_addr),
    .wr_data_i    (ram_wr_data)
  );

  icache_ctrl #(.CACHE_BYTES(CACHE_BYTES)) u_ctrl (
    .core_clock_i  (core_clock_i),
    .rst_i         (rst_i),
    .core_flush_i  (core_flush_i),
    .cache_flush_i (cache_flush_i),
    .flush_resp_o  (flush_resp_o),
    .work_vld_i    (work_vld),
    .work_req_i    (work_req),
    .stall_o       (stall),
    .pmp_addr_o    (pmp_addr_o),
    .pmp_kill_i    (pmp_kill_i),
    .hit_way_i     (hit_way),
    .victim_way_i  (victim_way),
    .fill_en_o     (fill_en),
    .fill_way_o    (fill_way),
    .flush_en_o    (flush_en),
    .flush_idx_o   (flush_idx),
    .flush_done_i  (flush_done),
    .ram_rd_en_o   (ram_rd_en),
    .ram_rd_addr_o (ram_rd_addr),
    .ram_wr_en_o   (ram_wr_en),
    .ram_wr_addr_o (ram_wr_addr),
    .ram_wr_data_o (ram_wr_data),
    .dec_vld_o     (dec_vld_o),
    .dec_meta_o    (dec_meta),
    .dec_busy_i    (dec_busy_i),
    .a_o           (a_o),
    .a_valid_o     (a_valid_o),
    .a_ready_i     (a_ready_i),
    .d_i           (d_i),
    .d_valid_i     (d_valid_i),
    .d_ready_o     (d_ready_o)
  );

  // Metadata and RAM data are registered on the same edge, so they line up
  always_comb begin
    dec_o       = dec_meta;
    dec_o.instr = ram_rd_data;
  end

endmodule

// ==== tb_icache_top.sv ====
`timescale 1ns/1ps

module tb_icache_top
  import icache_pkg::*;
();

  localparam int CACHE_BYTES    = 4096;
  localparam int SETS           = CACHE_BYTES / 256;
  localparam int TIMEOUT_CYCLES = 3000;
  // Word addresses; the three LINE_ values share set 8 but differ in tag
  localparam logic [29:0] P_COLD     = 30'h0012345;
  localparam logic [29:0] P_UNCACHED = 30'h2000_0100;
  localparam logic [29:0] P_KILL     = 30'h0003000;
  localparam logic [29:0] LINE_A     = 30'h0000100;
  localparam logic [29:0] LINE_B     = 30'h0000300;
  localparam logic [29:0] LINE_C     = 30'h0000500;

  logic        core_clock;
  logic        rst;
  logic        core_flush;
  logic        fetch_vld;
  fetch_req_t  fetch_req;
  logic        icache_busy;
  logic        dec_vld;
  dec_out_t    dec;
  logic        dec_busy;
  logic        cache_flush;
  logic        flush_resp;
  tl_a_t       a;
  logic        a_valid;
  logic        a_ready;
  tl_d_t       d;
  logic        d_valid;
  logic        d_ready;
  logic [24:0] pmp_addr;
  logic        pmp_kill;
  // Checker stand-in and the expectation flags for the current test
  logic        kill_en;
  logic [24:0] kill_line;
  logic        no_bus;
  logic        expect_blocked;
  logic        a_valid_prev;
  fetch_req_t  exp_q[$];
  int          seed;
  int          errors;
  int          gets;
  int          cycles;
  int          tests_run;
  int          tests_passed;

  icache_top #(.CACHE_BYTES(CACHE_BYTES)) u_dut (
    .core_clock_i  (core_clock),
    .rst_i         (rst),
    .core_flush_i  (core_flush),
    .fetch_vld_i   (fetch_vld),
    .fetch_req_i   (fetch_req),
    .icache_busy_o (icache_busy),
    .dec_vld_o     (dec_vld),
    .dec_o         (dec),
    .dec_busy_i    (dec_busy),
    .cache_flush_i (cache_flush),
    .flush_resp_o  (flush_resp),
    .a_o           (a),
    .a_valid_o     (a_valid),
    .a_ready_i     (a_ready),
    .d_i           (d),
    .d_valid_i     (d_valid),
    .d_ready_o     (d_ready),
    .pmp_addr_o    (pmp_addr),
    .pmp_kill_i    (pmp_kill)
  );

  tb_mem_model u_mem (
    .core_clock_i (core_clock),
    .rst_i        (rst),
    .a_i          (a),
    .a_valid_i    (a_valid),
    .a_ready_o    (a_ready),
    .d_o          (d),
    .d_valid_o    (d_valid),
    .d_ready_i    (d_ready)
  );

  // The permission checker answers in the same cycle for one chosen line
  assign pmp_kill = kill_en && (pmp_addr == kill_line);

  initial begin
    core_clock = 1'b0;
    forever #4 core_clock = ~core_clock;
  end

  // Byte address of the word, upper half inverted, as the bus memory defines it
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {~addr[31:16], addr[15:0]};
  endfunction

  // The even word sits in the low half of the pair, the odd word in the high half
  function automatic logic [63:0] pair_of(input logic [29:0] ppc);
    return {mem_word({ppc[29:1], 3'b100}), mem_word({ppc[29:1], 3'b000})};
  endfunction

  task automatic next_cycle();
    @(posedge core_clock);
    #1;
  endtask

  // Fetch holds its request until the cache is not busy at an edge
  task automatic send_fetch(input logic [29:0] ppc);
    fetch_req_t  req;
    logic [63:0] r;
    logic        taken;
    r         = {$random(seed), $random(seed)};
    req.ppc   = ppc;
    req.btb   = r[$bits(btb_info_t)-1:0];
    fetch_vld = 1'b1;
    fetch_req = req;
    taken     = 1'b0;
    while (!taken) begin
      taken = !icache_busy;
      next_cycle();
    end
    fetch_vld = 1'b0;
    exp_q.push_back(req);
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      next_cycle();
    end
  endtask

  task automatic wait_idle();
    while (!flush_resp) begin
      next_cycle();
    end
  endtask

  // A front-end flush throws away everything in flight
  task automatic pulse_core_flush();
    core_flush = 1'b1;
    next_cycle();
    core_flush = 1'b0;
    exp_q.delete();
  endtask

  task automatic check_delivery();
    fetch_req_t exp;
    logic       fault;
    delivery_expected: assert (exp_q.size() != 0) else begin
      $display("Decode output at %0t with no request outstanding", $time);
      errors++;
    end
    if (exp_q.size() != 0) begin
      exp   = exp_q.pop_front();
      fault = exp.ppc[29] || (kill_en && exp.ppc[29:5] == kill_line);
      vpc_ok: assert (dec.vpc == exp.ppc) else begin
        $display("Mismatch at %0t: vpc %h, expected %h", $time, dec.vpc, exp.ppc);
        errors++;
      end
      btb_ok: assert (dec.btb == exp.btb) else begin
        $display("Mismatch at %0t: sideband %h, expected %h", $time, dec.btb, exp.btb);
        errors++;
      end
      excp_ok: assert (dec.excp_vld == fault &&
                       (!fault || dec.excp_code == EXCP_INSTR_ACCESS_FAULT)) else begin
        $display("Mismatch at %0t: exception %b code %0d, expected %b", $time,
                 dec.excp_vld, dec.excp_code, fault);
        errors++;
      end
      instr_ok: assert (fault || dec.instr == pair_of(exp.ppc)) else begin
        $display("Mismatch at %0t: instr %h, expected %h", $time, dec.instr,
                 pair_of(exp.ppc));
        errors++;
      end
    end
  endtask

  // A Get is always for the line of the oldest undelivered request
  task automatic check_get();
    gets++;
    get_fields: assert (a.opcode == TL_GET && a.size == 4'(TL_SIZE_LINE) &&
                        a.param == 3'd0 && a.mask == 4'hf && !a.corrupt) else begin
      $display("Mismatch at %0t: opcode %0d param %0d size %0d mask %h corrupt %b",
               $time, a.opcode, a.param, a.size, a.mask, a.corrupt);
      errors++;
    end
    get_line: assert (exp_q.size() != 0 && a.address == {exp_q[0].ppc[29:5], 7'h00}) else begin
      $display("Mismatch at %0t: Get address %h not the line of the head request",
               $time, a.address);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      tests_passed++;
      $display("Test %0d %s: pass", tests_run, name);
    end else begin
      $display("Test %0d %s: fail with %0d errors", tests_run, name, errors - errors_before);
    end
  endtask

  // Outputs are looked at mid-cycle, where every register has settled
  always @(negedge core_clock) begin
    if (!rst) begin
      if (dec_vld && !dec_busy) begin
        check_delivery();
      end
      if (a_valid && !a_valid_prev) begin
        check_get();
      end
    end
    a_valid_prev = a_valid;
  end

  hold_while_busy: assert property (@(posedge core_clock) disable iff (rst)
    dec_vld && dec_busy && !core_flush |=> dec_vld && $stable(dec)) else begin
    $display("Mismatch at %0t: decode output moved while decode was busy", $time);
    errors++;
  end

  fault_skips_bus: assert property (@(posedge core_clock) disable iff (rst)
    no_bus |-> !a_valid) else begin
    $display("Bus request raised for a faulting fetch at %0t", $time);
    errors++;
  end

  blocked_after_flush: assert property (@(posedge core_clock) disable iff (rst)
    expect_blocked |-> !dec_vld) else begin
    $display("Decode output delivered before the front end was flushed at %0t", $time);
    errors++;
  end

  always @(posedge core_clock) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run hung: still busy after %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int mark;
    int g;
    int n;
    rst            = 1'b1;
    core_flush     = 1'b0;
    fetch_vld      = 1'b0;
    fetch_req      = '0;
    dec_busy       = 1'b0;
    cache_flush    = 1'b0;
    kill_en        = 1'b0;
    kill_line      = '0;
    no_bus         = 1'b0;
    expect_blocked = 1'b0;
    a_valid_prev   = 1'b0;
    seed           = 18;
    errors         = 0;
    gets           = 0;
    cycles         = 0;
    tests_run      = 0;
    tests_passed   = 0;
    repeat (4) @(posedge core_clock);
    #1;
    rst = 1'b0;

    mark = errors;
    reset_outputs: assert (!dec_vld && !a_valid && !icache_busy && flush_resp &&
                           d_ready) else begin
      $display("An output is not at its reset value at %0t", $time);
      errors++;
    end
    g = gets;
    send_fetch(P_COLD);
    wait_drained();
    cold_miss: assert (gets == g + 1) else begin
      $display("Mismatch at %0t: %0d Gets for a cold fetch, expected 1", $time, gets - g);
      errors++;
    end
    // Both words of the pair now come from the cache
    send_fetch(P_COLD);
    send_fetch(P_COLD ^ 30'h1);
    wait_drained();
    warm_hit: assert (gets == g + 1) else begin
      $display("Mismatch at %0t: refetch of a cached pair went to the bus", $time);
      errors++;
    end
    report_test("miss then hit", mark);

    // Back to back so hits queue up behind misses
    mark = errors;
    send_fetch(30'h0000040);
    send_fetch(30'h0000041);
    send_fetch(30'h0001000);
    send_fetch(30'h0000047);
    send_fetch(30'h0001003);
    send_fetch(30'h0002010);
    send_fetch(30'h0000040);
    wait_drained();
    report_test("sideband and pc", mark);

    mark = errors;
    no_bus = 1'b1;
    send_fetch(P_UNCACHED);
    pmp_uncached: assert (pmp_addr == P_UNCACHED[29:5]) else begin
      $display("Mismatch at %0t: pmp_addr %h, expected %h", $time, pmp_addr,
               P_UNCACHED[29:5]);
      errors++;
    end
    kill_line = P_KILL[29:5];
    kill_en   = 1'b1;
    send_fetch(P_KILL);
    pmp_killed: assert (pmp_addr == P_KILL[29:5]) else begin
      $display("Mismatch at %0t: pmp_addr %h, expected %h", $time, pmp_addr, P_KILL[29:5]);
      errors++;
    end
    send_fetch(P_KILL + 30'h4);
    wait_drained();
    no_bus  = 1'b0;
    kill_en = 1'b0;
    report_test("exceptions", mark);

    mark = errors;
    send_fetch(LINE_A);
    wait_drained();
    send_fetch(LINE_B);
    wait_drained();
    g = gets;
    send_fetch(LINE_C);
    wait_drained();
    third_miss: assert (gets == g + 1) else begin
      $display("Mismatch at %0t: third line in a full set did not miss", $time);
      errors++;
    end
    g = gets;
    send_fetch(LINE_A + 30'h2);
    while (!dec_vld && gets == g) begin
      next_cycle();
    end
    // Line A was evicted, so drop its refill and line B has to be the survivor
    if (gets != g) begin
      pulse_core_flush();
      wait_idle();
      g = gets;
      send_fetch(LINE_B + 30'h2);
    end
    wait_drained();
    survivor_hit: assert (gets == g) else begin
      $display("Mismatch at %0t: neither of the first two lines survived", $time);
      errors++;
    end
    report_test("replacement", mark);

    mark = errors;
    cache_flush = 1'b1;
    next_cycle();
    cache_flush = 1'b0;
    flush_taken: assert (!flush_resp) else begin
      $display("Cache flush was not accepted at %0t", $time);
      errors++;
    end
    n = 0;
    while (!flush_resp) begin
      n++;
      next_cycle();
    end
    sweep_length: assert (n == SETS) else begin
      $display("Mismatch at %0t: sweep took %0d cycles, expected %0d", $time, n, SETS);
      errors++;
    end
    // A faulting request would be answered in one cycle without the block
    // so it waits at the head only while delivery is held off
    expect_blocked = 1'b1;
    send_fetch(P_UNCACHED);
    repeat (20) next_cycle();
    pulse_core_flush();
    expect_blocked = 1'b0;
    g = gets;
    send_fetch(P_COLD);
    wait_drained();
    miss_after_flush: assert (gets == g + 1) else begin
      $display("Mismatch at %0t: a line survived the cache flush", $time);
      errors++;
    end
    report_test("flush", mark);

    mark = errors;
    send_fetch(30'h0012340);
    while (!dec_vld) begin
      next_cycle();
    end
    dec_busy = 1'b1;
    send_fetch(30'h0012342);
    one_queued: assert (!icache_busy) else begin
      $display("Mismatch at %0t: busy raised with only one request queued", $time);
      errors++;
    end
    send_fetch(30'h0012350);
    two_queued: assert (icache_busy) else begin
      $display("Mismatch at %0t: busy low with two requests queued", $time);
      errors++;
    end
    repeat (4) next_cycle();
    dec_busy = 1'b0;
    send_fetch(30'h001235e);
    wait_drained();
    report_test("back-pressure", mark);

    $display("%0d of %0d tests passed, %0d errors", tests_passed, tests_run, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model
  import icache_pkg::*;
(
  input  logic  core_clock_i,
  input  logic  rst_i,
  input  tl_a_t a_i,
  input  logic  a_valid_i,
  output logic  a_ready_o,
  output tl_d_t d_o,
  output logic  d_valid_o,
  input  logic  d_ready_i
);

  int          seed;
  logic        accept;
  logic        busy;
  int          beat;
  logic [31:0] base;

  // Every word reads back as its own byte address with the upper half inverted
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return {~addr[31:16], addr[15:0]};
  endfunction

  initial begin
    seed      = 18;
    accept    = 1'b0;
    busy      = 1'b0;
    beat      = 0;
    base      = '0;
    a_ready_o = 1'b0;
    d_valid_o = 1'b0;
    d_o       = '0;
    forever begin
      @(posedge core_clock_i);
      #1;
      if (rst_i) begin
        accept    = 1'b0;
        busy      = 1'b0;
        a_ready_o = 1'b0;
        d_valid_o = 1'b0;
      end else begin
        // A beat that was offered before this edge has been taken by the cache
        if (d_valid_o && d_ready_i) begin
          beat++;
          busy = beat < LINE_BEATS;
        end
        // The Get that met a_ready on this edge opens a burst for its whole line
        if (accept) begin
          busy = 1'b1;
          beat = 0;
          base = {a_i.address[31:7], 7'h00};
        end
        // About one cycle in four is a gap between beats
        d_valid_o = busy && (($random(seed) & 3) != 0);
        d_o.data  = word_at(base + 32'(beat * 4));
        // Ready is random too, and only offered when no burst is running
        a_ready_o = !busy && (($random(seed) & 1) != 0);
        // a_valid and a_ready both hold until the next edge, which decides the handshake
        accept    = a_valid_i && a_ready_o;
      end
    end
  end

endmodule

// ==== vlog.f ====
icache_pkg.sv
fetch_skid_buffer.sv
icache_data_ram.sv
icache_tag_array.sv
icache_ctrl.sv
icache_top.sv
tb_mem_model.sv
tb_icache_top.sv
